/* texmem_pkg.sv */
package texmem_pkg;

	// ********************
	// Geometry
	// ********************
	localparam int LINE_OFFSET_W = 5;   // 32-byte lines
	localparam int TEXEL_W = 16;        // RGB565 texel
	localparam int FRAC_W = 6;          // Filter fraction
	localparam int BEAT_W = 64;         // One memory beat
	localparam int LINE_W = 256;        // Four beats
	localparam int DADR_W = 15;         // Destination word address
	localparam int IDX_W = 8;           // Cache byte address, index and offset

	// Fragment after the tag stage
	typedef struct packed {
		logic [DADR_W-1:0] dadr;
		logic [IDX_W-1:0] tadr_idx;     // Position in the data RAM
		logic [FRAC_W-1:0] x_frac;
		logic [FRAC_W-1:0] y_frac;
		logic miss;                     // Line must be fetched first
	} frag_t;

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_REQUEST,                  // Waiting for memory ack
		FETCH_BURST                     // Beats 1 to 3
	} fetch_state_e;

	typedef enum logic [1:0] {
		DATA_IDLE,
		DATA_WAIT_LINE,                 // Miss pending, line not yet here
		DATA_PRESENT                    // Line written, read it back
	} data_state_e;

endpackage

/* texmem_tag_if.sv */
`timescale 1ns/100ps

// Tag stage to split stage link
interface texmem_tag_if #(
	parameter int fml_depth = 16
);
	import texmem_pkg::*;

	logic stb;
	logic ack;
	logic [fml_depth-2:0] dadr;   // 16-bit word address
	logic [fml_depth-1:0] tadr;   // Byte address
	logic [FRAC_W-1:0] x_frac;
	logic [FRAC_W-1:0] y_frac;
	logic miss;

	modport tagmem (
		output stb, dadr, tadr, x_frac, y_frac, miss,
		input ack
	);

	modport split (
		input stb, dadr, tadr, x_frac, y_frac, miss,
		output ack
	);

endinterface

/* texmem_buffer.sv */
`timescale 1ns/100ps

module texmem_buffer #(
	parameter int width = 8,
	parameter int depth = 4
) (
	input logic sys_clk,
	input logic rst_n_i,
	output logic busy_o,
	input logic pipe_stb_i,
	output logic pipe_ack_o,
	input logic [width-1:0] dat_i,
	output logic pipe_stb_o,
	input logic pipe_ack_i,
	output logic [width-1:0] dat_o
);
	localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
	localparam int LVL_W = $clog2(depth + 1);

	logic [width-1:0] mem [depth];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [LVL_W-1:0] level;
	logic push;
	logic pop;

	assign pipe_ack_o = (level != LVL_W'(depth));   // Ready while not full
	assign pipe_stb_o = (level != '0);
	assign dat_o = mem[rd_ptr];
	assign busy_o = pipe_stb_o;
	assign push = pipe_stb_i && pipe_ack_o;
	assign pop = pipe_stb_o && pipe_ack_i;

	always_ff @(posedge sys_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(depth - 1)) ? '0 : wr_ptr + 1'b1;  // Any depth
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (push)
			mem[wr_ptr] <= dat_i;
	end

	// An offer to a full FIFO waits unchanged instead of being pushed
	a_no_push_full: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
		(pipe_stb_i && level == LVL_W'(depth)) |=> (pipe_stb_i && $stable(dat_i)));

endmodule

/* texmem_tagmem.sv */
`timescale 1ns/100ps

module texmem_tagmem #(
	parameter int cache_depth = 8,
	parameter int fml_depth = 16
) (
	input logic sys_clk,
	input logic rst_n_i,
	input logic flush_i,
	output logic busy_o,
	input logic pipe_stb_i,
	output logic pipe_ack_o,
	input logic [fml_depth-2:0] dadr_i,
	input logic [fml_depth-2:0] tadr_i,
	input logic [texmem_pkg::FRAC_W-1:0] x_frac_i,
	input logic [texmem_pkg::FRAC_W-1:0] y_frac_i,
	texmem_tag_if.tagmem tag_o
);
	import texmem_pkg::*;

	// | TAG | INDEX | OFFSET |, byte granularity
	localparam int TAG_W = fml_depth - cache_depth;
	localparam int LINES = 2 ** (cache_depth - LINE_OFFSET_W);

	logic [TAG_W-1:0] tags [LINES];
	logic [LINES-1:0] valid;
	logic [fml_depth-1:0] tadr8;
	logic [cache_depth-LINE_OFFSET_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic hit;
	logic out_valid;
	logic flushing;                                   // Valid bits clear this cycle
	logic take;

	assign tadr8 = {tadr_i, 1'b0};                    // Words to bytes
	assign idx = tadr8[cache_depth-1:LINE_OFFSET_W];
	assign tag = tadr8[fml_depth-1:cache_depth];
	assign hit = valid[idx] && (tags[idx] == tag);

	// Output register free or draining, no flush around
	assign pipe_ack_o = pipe_stb_i && (!out_valid || tag_o.ack) && !flushing && !flush_i;
	assign take = pipe_stb_i && pipe_ack_o;
	assign tag_o.stb = out_valid;
	assign busy_o = out_valid || flushing;

	always_ff @(posedge sys_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			out_valid <= 1'b0;
			flushing <= 1'b0;
			valid <= '0;                                  // All lines invalid
		end else begin
			flushing <= flush_i;
			if (take)
				out_valid <= 1'b1;
			else if (tag_o.ack)
				out_valid <= 1'b0;
			if (flushing)
				valid <= '0;
			else if (take && !hit)
				valid[idx] <= 1'b1;                         // Claimed at once
		end
	end

	always_ff @(posedge sys_clk) begin
		if (take) begin
			if (!hit)
				tags[idx] <= tag;                           // Next fragment in line hits
			tag_o.dadr <= dadr_i;
			tag_o.tadr <= tadr8;
			tag_o.x_frac <= x_frac_i;
			tag_o.y_frac <= y_frac_i;
			tag_o.miss <= !hit;
		end
	end

	// Flush only from an idle cache
	a_flush_idle: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
		flush_i |-> !busy_o);

endmodule

/* texmem_split.sv */
`timescale 1ns/100ps

module texmem_split #(
	parameter int cache_depth = 8,
	parameter int fml_depth = 16
) (
	input logic sys_clk,
	input logic rst_n_i,
	texmem_tag_if.split tag_i,
	output logic frag_stb_o,
	input logic frag_ack_i,
	output texmem_pkg::frag_t frag_o,
	output logic fetch_stb_o,
	input logic fetch_ack_i,
	output logic [fml_depth-texmem_pkg::LINE_OFFSET_W-1:0] fetch_adr_o
);
	import texmem_pkg::*;

	logic ready;

	// Both queues take it or neither does
	assign ready = frag_ack_i && (!tag_i.miss || fetch_ack_i);
	assign tag_i.ack = ready;

	assign frag_stb_o = tag_i.stb && (!tag_i.miss || fetch_ack_i);
	assign fetch_stb_o = tag_i.stb && tag_i.miss && frag_ack_i;  // Misses only

	// ********************
	// Field routing
	// ********************
	assign frag_o.dadr = tag_i.dadr;
	assign frag_o.tadr_idx = tag_i.tadr[cache_depth-1:0];        // Index and offset
	assign frag_o.x_frac = tag_i.x_frac;
	assign frag_o.y_frac = tag_i.y_frac;
	assign frag_o.miss = tag_i.miss;
	assign fetch_adr_o = tag_i.tadr[fml_depth-1:LINE_OFFSET_W]; // Line address

	// Tag stage holds its offer until it is taken
	a_offer_hold: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
		(tag_i.stb && !tag_i.ack) |=> (tag_i.stb && $stable(tag_i.tadr) && $stable(tag_i.miss)));

endmodule

/* texmem_fetchtexel.sv */
`timescale 1ns/100ps

module texmem_fetchtexel #(
	parameter int fml_depth = 16
) (
	input logic sys_clk,
	input logic rst_n_i,
	output logic busy_o,
	input logic pipe_stb_i,
	output logic pipe_ack_o,
	input logic [fml_depth-texmem_pkg::LINE_OFFSET_W-1:0] fetch_adr_i,
	output logic pipe_stb_o,
	input logic pipe_ack_i,
	output logic [texmem_pkg::LINE_W-1:0] line_o,
	output logic [fml_depth-1:0] fml_adr_o,
	output logic fml_stb_o,
	input logic fml_ack_i,
	input logic [texmem_pkg::BEAT_W-1:0] fml_di_i
);
	import texmem_pkg::*;

	fetch_state_e state;
	logic [fml_depth-LINE_OFFSET_W-1:0] adr_q;
	logic [1:0] beat_cnt;
	logic [LINE_W-1:0] line_q;
	logic line_valid;                                       // Line held for datamem
	logic beat_en;

	assign beat_en = (state == FETCH_REQUEST && fml_ack_i) || (state == FETCH_BURST);
	assign pipe_ack_o = (state == FETCH_IDLE) && !line_valid;
	assign fml_stb_o = (state == FETCH_REQUEST);
	assign fml_adr_o = {adr_q, {LINE_OFFSET_W{1'b0}}};     // Line aligned
	assign pipe_stb_o = line_valid;
	assign line_o = line_q;
	assign busy_o = (state != FETCH_IDLE) || line_valid;

	always_ff @(posedge sys_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= FETCH_IDLE;
			beat_cnt <= 2'd0;
			line_valid <= 1'b0;
		end else begin
			if (line_valid && pipe_ack_i)
				line_valid <= 1'b0;
			case (state)
				FETCH_IDLE: if (pipe_stb_i && pipe_ack_o)
					state <= FETCH_REQUEST;
				FETCH_REQUEST: if (fml_ack_i) begin
					state <= FETCH_BURST;                         // Beat 0 came with ack
					beat_cnt <= 2'd1;
				end
				FETCH_BURST: begin
					beat_cnt <= beat_cnt + 2'd1;                  // Wraps back to 0
					if (beat_cnt == 2'd3) begin
						state <= FETCH_IDLE;
						line_valid <= 1'b1;
					end
				end
				default: state <= FETCH_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_stb_i && pipe_ack_o)
			adr_q <= fetch_adr_i;
		if (beat_en)
			line_q[beat_cnt*BEAT_W +: BEAT_W] <= fml_di_i;  // Lowest bytes first
	end

	// Request held steady until the memory takes it
	a_adr_stable: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
		(fml_stb_o && !fml_ack_i) |=> (fml_stb_o && $stable(fml_adr_o)));

endmodule

/* texmem_datamem.sv */
`timescale 1ns/100ps

module texmem_datamem #(
	parameter int cache_depth = 8,
	parameter int fml_depth = 16
) (
	input logic sys_clk,
	input logic rst_n_i,
	output logic busy_o,
	input logic frag_stb_i,
	output logic frag_ack_o,
	input texmem_pkg::frag_t frag_i,
	input logic line_stb_i,
	output logic line_ack_o,
	input logic [texmem_pkg::LINE_W-1:0] line_i,
	output logic pipe_stb_o,
	input logic pipe_ack_i,
	output logic [fml_depth-2:0] dadr_o,
	output logic [texmem_pkg::TEXEL_W-1:0] tcolor_o,
	output logic [texmem_pkg::FRAC_W-1:0] x_frac_o,
	output logic [texmem_pkg::FRAC_W-1:0] y_frac_o
);
	import texmem_pkg::*;

	logic [7:0] mem [2**cache_depth];                    // Byte-wide cache RAM
	data_state_e state;
	frag_t frag_q;                                       // Fragment waiting for its line
	frag_t frag_sel;
	logic [cache_depth-1:0] rd_adr;
	logic out_valid;
	logic out_free;
	logic frag_take;
	logic line_take;
	logic load;

	assign out_free = !out_valid || pipe_ack_i;
	assign frag_ack_o = (state == DATA_IDLE) && out_free;
	assign frag_take = frag_stb_i && frag_ack_o;
	assign line_ack_o = (state == DATA_WAIT_LINE);       // Lines come in miss order
	assign line_take = line_stb_i && line_ack_o;
	assign load = (frag_take && !frag_i.miss) || (state == DATA_PRESENT && out_free);
	assign frag_sel = (state == DATA_PRESENT) ? frag_q : frag_i;
	assign rd_adr = frag_sel.tadr_idx[cache_depth-1:0];
	assign pipe_stb_o = out_valid;
	assign busy_o = (state != DATA_IDLE) || out_valid;

	// ********************
	// Miss sequencing
	// ********************
	always_ff @(posedge sys_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= DATA_IDLE;
			out_valid <= 1'b0;
		end else begin
			if (load)
				out_valid <= 1'b1;
			else if (pipe_ack_i)
				out_valid <= 1'b0;
			case (state)
				DATA_IDLE: if (frag_take && frag_i.miss)
					state <= DATA_WAIT_LINE;
				DATA_WAIT_LINE: if (line_take)
					state <= DATA_PRESENT;
				DATA_PRESENT: if (out_free)
					state <= DATA_IDLE;
				default: state <= DATA_IDLE;
			endcase
		end
	end

	// Older fragments already read the old line, replace it now
	always_ff @(posedge sys_clk) begin
		if (frag_take)
			frag_q <= frag_i;
		if (line_take) begin
			for (int b = 0; b < LINE_W / 8; b++)
				mem[{frag_q.tadr_idx[cache_depth-1:LINE_OFFSET_W], LINE_OFFSET_W'(b)}]
					<= line_i[8*b +: 8];                       // Byte b at bits 8b
		end
		if (load) begin
			dadr_o <= frag_sel.dadr;
			tcolor_o <= {mem[{rd_adr[cache_depth-1:1], 1'b1}],
				mem[{rd_adr[cache_depth-1:1], 1'b0}]};       // Little endian texel
			x_frac_o <= frag_sel.x_frac;
			y_frac_o <= frag_sel.y_frac;
		end
	end

endmodule

/* texmem_top.sv */
`timescale 1ns/100ps

module texmem_top #(
	parameter int cache_depth = 8,   // log2 of cache bytes
	parameter int fml_depth = 16     // Memory byte address width
) (
	input logic sys_clk,
	input logic rst_n_i,
	input logic pipe_stb_i,
	output logic pipe_ack_o,
	input logic [fml_depth-2:0] dadr_i,
	input logic [fml_depth-2:0] tadr_i,
	input logic [texmem_pkg::FRAC_W-1:0] x_frac_i,
	input logic [texmem_pkg::FRAC_W-1:0] y_frac_i,
	output logic pipe_stb_o,
	input logic pipe_ack_i,
	output logic [fml_depth-2:0] dadr_o,
	output logic [texmem_pkg::TEXEL_W-1:0] tcolor_o,
	output logic [texmem_pkg::FRAC_W-1:0] x_frac_o,
	output logic [texmem_pkg::FRAC_W-1:0] y_frac_o,
	output logic [fml_depth-1:0] fml_adr_o,
	output logic fml_stb_o,
	input logic fml_ack_i,
	input logic [texmem_pkg::BEAT_W-1:0] fml_di_i,
	input logic flush_i,
	output logic busy_o
);
	import texmem_pkg::*;

	localparam int LADR_W = fml_depth - LINE_OFFSET_W;

	logic tagmem_busy, fragf_busy, fetchf_busy, fetchtexel_busy, datamem_busy;
	logic split_frag_stb, split_frag_ack, fragf_stb, fragf_ack;
	logic split_fetch_stb, split_fetch_ack, fetchf_stb, fetchf_ack;
	logic fetchtexel_stb, fetchtexel_ack;
	frag_t split_frag, fragf_frag;
	logic [LADR_W-1:0] split_fetch_adr, fetchf_adr;
	logic [LINE_W-1:0] fetchtexel_line;

	texmem_tag_if #(.fml_depth(fml_depth)) tag_bus ();

	// ********************
	// Tag and split
	// ********************
	texmem_tagmem #(.cache_depth(cache_depth), .fml_depth(fml_depth)) tagmem (
		.sys_clk, .rst_n_i, .flush_i, .busy_o(tagmem_busy),
		.pipe_stb_i, .pipe_ack_o, .dadr_i, .tadr_i, .x_frac_i, .y_frac_i,
		.tag_o(tag_bus.tagmem)
	);

	texmem_split #(.cache_depth(cache_depth), .fml_depth(fml_depth)) split (
		.sys_clk, .rst_n_i, .tag_i(tag_bus.split),
		.frag_stb_o(split_frag_stb), .frag_ack_i(split_frag_ack), .frag_o(split_frag),
		.fetch_stb_o(split_fetch_stb), .fetch_ack_i(split_fetch_ack),
		.fetch_adr_o(split_fetch_adr)
	);

	// ********************
	// Queues
	// ********************
	texmem_buffer #(.width($bits(frag_t)), .depth(4)) frag_fifo (
		.sys_clk, .rst_n_i, .busy_o(fragf_busy),
		.pipe_stb_i(split_frag_stb), .pipe_ack_o(split_frag_ack), .dat_i(split_frag),
		.pipe_stb_o(fragf_stb), .pipe_ack_i(fragf_ack), .dat_o(fragf_frag)
	);

	texmem_buffer #(.width(LADR_W), .depth(3)) fetch_fifo (
		.sys_clk, .rst_n_i, .busy_o(fetchf_busy),
		.pipe_stb_i(split_fetch_stb), .pipe_ack_o(split_fetch_ack), .dat_i(split_fetch_adr),
		.pipe_stb_o(fetchf_stb), .pipe_ack_i(fetchf_ack), .dat_o(fetchf_adr)
	);

	texmem_fetchtexel #(.fml_depth(fml_depth)) fetchtexel (
		.sys_clk, .rst_n_i, .busy_o(fetchtexel_busy),
		.pipe_stb_i(fetchf_stb), .pipe_ack_o(fetchf_ack), .fetch_adr_i(fetchf_adr),
		.pipe_stb_o(fetchtexel_stb), .pipe_ack_i(fetchtexel_ack), .line_o(fetchtexel_line),
		.fml_adr_o, .fml_stb_o, .fml_ack_i, .fml_di_i
	);

	texmem_datamem #(.cache_depth(cache_depth), .fml_depth(fml_depth)) datamem (
		.sys_clk, .rst_n_i, .busy_o(datamem_busy),
		.frag_stb_i(fragf_stb), .frag_ack_o(fragf_ack), .frag_i(fragf_frag),
		.line_stb_i(fetchtexel_stb), .line_ack_o(fetchtexel_ack), .line_i(fetchtexel_line),
		.pipe_stb_o, .pipe_ack_i, .dadr_o, .tcolor_o, .x_frac_o, .y_frac_o
	);

	assign busy_o = tagmem_busy | fragf_busy | fetchf_busy
		| fetchtexel_busy | datamem_busy;   // Split holds no state

endmodule

/* tb_texmem.sv */
`timescale 1ns/100ps

module tb_texmem;

	localparam int CACHE_DEPTH = 8;
	localparam int FML_DEPTH = 16;
	localparam int LINES = 2 ** (CACHE_DEPTH - 5);      // 32-byte lines
	localparam int SEND_TIMEOUT = 200;                  // Cycles per input handshake
	localparam int DRAIN_TIMEOUT = 1000;                // Cycles per table
	localparam int IDLE_TIMEOUT = 100;

	typedef struct {
		string name;
		logic [14:0] dadr;
		logic [14:0] tadr;                                // Texel word address
		logic [5:0] x_frac;
		logic [5:0] y_frac;
		bit miss;                                         // From the tag model
	} stim_t;

	logic sys_clk;
	logic rst_n_i;
	logic pipe_stb_i, pipe_ack_o, pipe_stb_o, pipe_ack_i;
	logic [14:0] dadr_i, tadr_i, dadr_o;
	logic [5:0] x_frac_i, y_frac_i, x_frac_o, y_frac_o;
	logic [15:0] tcolor_o;
	logic [15:0] fml_adr_o;
	logic fml_stb_o, fml_ack_i;
	logic [63:0] fml_di_i;
	logic flush_i, busy_o;

	stim_t stim_table [$];
	stim_t expect_q [$];                                // Scoreboard in input order
	int unsigned ref_tag [LINES];
	bit ref_valid [LINES];
	int checks = 0;
	int errors = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int req_count = 0;
	bit bp_on = 1'b0;                                   // Random pipe_ack_i
	bit timed_out = 1'b0;
	bit fml_stb_q = 1'b0;

	texmem_top #(.cache_depth(CACHE_DEPTH), .fml_depth(FML_DEPTH)) u_dut (
		.sys_clk, .rst_n_i, .pipe_stb_i, .pipe_ack_o, .dadr_i, .tadr_i, .x_frac_i, .y_frac_i,
		.pipe_stb_o, .pipe_ack_i, .dadr_o, .tcolor_o, .x_frac_o, .y_frac_o,
		.fml_adr_o, .fml_stb_o, .fml_ack_i, .fml_di_i, .flush_i, .busy_o
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;                    // 4 ns period
	end

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			test_errors++;
			$display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	task automatic note_fault(input string msg);
		errors++;
		test_errors++;
		$display("%s", msg);
	endtask

	// Direct-mapped rule where a miss claims the line at once
	function automatic bit model_miss(input logic [14:0] tadr);
		int idx;
		int unsigned tag;
		idx = (tadr >> 4) % LINES;                        // Word bits above the 16-word line
		tag = tadr >> (CACHE_DEPTH - 1);
		model_miss = !(ref_valid[idx] && ref_tag[idx] == tag);
		ref_valid[idx] = 1'b1;
		ref_tag[idx] = tag;
	endfunction

	// Word w of memory holds w ^ 5a5a with four words per beat
	function automatic logic [63:0] beat_data(input logic [15:0] line_adr, input int k);
		logic [15:0] word;
		for (int j = 0; j < 4; j++) begin
			word = 16'(line_adr >> 1) + 16'(4 * k + j);
			beat_data[16*j +: 16] = word ^ 16'h5a5a;
		end
	endfunction

	task automatic add_entry(input string name, input logic [14:0] tadr);
		stim_t s;
		s.name = name;
		s.dadr = 15'($urandom);
		s.tadr = tadr;
		s.x_frac = 6'($urandom);
		s.y_frac = 6'($urandom);
		s.miss = model_miss(tadr);
		stim_table.push_back(s);
	endtask

	// Starts on a falling edge and returns on the falling edge after the handshake
	task automatic send_entry(input stim_t s);
		int wait_cnt;
		wait_cnt = 0;
		pipe_stb_i = 1'b1;
		dadr_i = s.dadr;
		tadr_i = s.tadr;
		x_frac_i = s.x_frac;
		y_frac_i = s.y_frac;
		#1;                                               // pipe_ack_o settled
		while (!pipe_ack_o && !timed_out) begin
			@(negedge sys_clk);
			#1;
			wait_cnt++;
			if (wait_cnt > SEND_TIMEOUT) begin
				$display("Timeout: pipe_ack_o stayed low for %s", s.name);
				timed_out = 1'b1;
			end
		end
		if (!timed_out) begin
			expect_q.push_back(s);                          // Taken at the next rising edge
			@(negedge sys_clk);
			check_value({s.name, " busy"}, 1, busy_o);
		end
	endtask

	task automatic drain(input string name);
		int wait_cnt;
		wait_cnt = 0;
		while (!timed_out && (expect_q.size() != 0 || busy_o)) begin
			if (expect_q.size() != 0 && !busy_o)
				note_fault($sformatf("busy_o low while fragments of %s are in flight", name));
			@(negedge sys_clk);
			wait_cnt++;
			if (wait_cnt > DRAIN_TIMEOUT) begin
				$display("Timeout: %s left %0d fragments undelivered", name, expect_q.size());
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic run_table(input string name, input bit bp, input int gap_max);
		int req_start;
		int exp_req;
		int gap;
		req_start = req_count;
		exp_req = 0;
		foreach (stim_table[i])
			if (stim_table[i].miss)
				exp_req++;
		bp_on = bp;
		@(negedge sys_clk);
		foreach (stim_table[i]) begin
			if (!timed_out) begin
				send_entry(stim_table[i]);
				gap = $urandom_range(gap_max, 0);
				if (gap > 0) begin
					pipe_stb_i = 1'b0;
					repeat (gap) @(negedge sys_clk);
				end
			end
		end
		pipe_stb_i = 1'b0;
		drain(name);
		if (!timed_out)
			check_value({name, " requests"}, exp_req, req_count - req_start);
		stim_table.delete();
	endtask

	task automatic flush_cache();
		int wait_cnt;
		wait_cnt = 0;
		while (busy_o && !timed_out) begin                // Flush only from idle
			@(negedge sys_clk);
			wait_cnt++;
			if (wait_cnt > IDLE_TIMEOUT) begin
				$display("Timeout: busy_o never fell before flush");
				timed_out = 1'b1;
			end
		end
		flush_i = 1'b1;
		@(negedge sys_clk);
		flush_i = 1'b0;
		check_value("flush busy", 1, busy_o);             // Valid bits clearing
		foreach (ref_valid[i])
			ref_valid[i] = 1'b0;
		@(negedge sys_clk);
		check_value("flush done busy", 0, busy_o);
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errors == 0 && !timed_out) begin
			$display("[PASS] %s", name);
		end else begin
			tests_failed++;
			$display("[FAIL] %s, %0d mismatches", name, test_errors);
		end
		test_errors = 0;
	endtask

	// ********************
	// Memory and output side
	// ********************
	initial begin : memory_model
		logic [15:0] adr;
		int delay;
		fml_ack_i = 1'b0;
		fml_di_i = '0;
		forever begin
			@(negedge sys_clk);
			if (fml_stb_o === 1'b1) begin
				delay = $urandom_range(5, 0);
				repeat (delay) @(negedge sys_clk);
				adr = fml_adr_o;
				fml_ack_i = 1'b1;
				fml_di_i = beat_data(adr, 0);                 // Beat 0 with the ack
				for (int k = 1; k < 4; k++) begin
					@(negedge sys_clk);
					fml_ack_i = 1'b0;
					fml_di_i = beat_data(adr, k);
				end
			end
		end
	end

	initial begin : request_counter
		forever begin
			@(negedge sys_clk);
			if (fml_stb_o === 1'b1 && !fml_stb_q)
				req_count++;                                  // Rising edge of fml_stb_o
			fml_stb_q = (fml_stb_o === 1'b1);
		end
	end

	initial begin : output_sink
		stim_t exp;
		bit held;
		logic [42:0] held_val;
		held = 1'b0;
		held_val = '0;
		pipe_ack_i = 1'b0;
		forever begin
			@(negedge sys_clk);
			if (held) begin                                 // Stalled output must not move
				check_value("output hold stb", 1, pipe_stb_o);
				check_value("output hold data", held_val, {dadr_o, tcolor_o, x_frac_o, y_frac_o});
			end
			pipe_ack_i = bp_on ? ($urandom_range(3, 0) != 0) : 1'b1;
			held = pipe_stb_o && !pipe_ack_i;
			held_val = {dadr_o, tcolor_o, x_frac_o, y_frac_o};
			if (pipe_stb_o && pipe_ack_i) begin
				if (expect_q.size() == 0) begin
					note_fault("Output fragment appeared with none outstanding");
				end else begin
					exp = expect_q.pop_front();
					check_value({exp.name, " dadr"}, exp.dadr, dadr_o);
					check_value({exp.name, " tcolor"}, {1'b0, exp.tadr} ^ 16'h5a5a, tcolor_o);
					check_value({exp.name, " x_frac"}, exp.x_frac, x_frac_o);
					check_value({exp.name, " y_frac"}, exp.y_frac, y_frac_o);
				end
			end
		end
	end

	// ********************
	// Test sequence
	// ********************
	initial begin : main
		void'($urandom(32'hfba8_fed7));
		rst_n_i = 1'b0;
		pipe_stb_i = 1'b0;
		dadr_i = '0;
		tadr_i = '0;
		x_frac_i = '0;
		y_frac_i = '0;
		flush_i = 1'b0;
		foreach (ref_valid[i])
			ref_valid[i] = 1'b0;
		repeat (4) @(posedge sys_clk);
		@(negedge sys_clk);
		rst_n_i = 1'b1;

		add_entry("cold_miss", 15'h0123);                 // Line of words 120..12f
		add_entry("same_line_hit_a", 15'h0125);
		add_entry("same_line_hit_b", 15'h012f);
		run_table("cold_miss_hit", 1'b0, 2);
		end_test("cold_miss_hit");

		for (int i = 0; i < 8; i++)                       // Index 4 with tags 0 and 1
			add_entry($sformatf("evict_%0d", i), ((i % 2) ? 15'h00c0 : 15'h0040) + 15'(i));
		run_table("evict_alternate", 1'b1, 0);
		end_test("evict_alternate");

		for (int i = 0; i < 40; i++)
			add_entry($sformatf("random_%0d", i), 15'($urandom_range(0, 511)));
		run_table("random_stream", 1'b1, 2);
		end_test("random_stream");

		add_entry("flush_fill", 15'h0200);
		add_entry("flush_hit", 15'h0204);
		run_table("flush_refetch_fill", 1'b0, 0);
		flush_cache();
		add_entry("flush_refetch", 15'h0208);              // Cached line that is now invalid
		run_table("flush_refetch", 1'b0, 0);
		end_test("flush_refetch");

		$display("Tests: %0d run, %0d passed, %0d failed; checks: %0d, errors: %0d",
			tests_run, tests_run - tests_failed, tests_failed, checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* sources.f */
texmem_pkg.sv
texmem_tag_if.sv
texmem_buffer.sv
texmem_tagmem.sv
texmem_split.sv
texmem_fetchtexel.sv
texmem_datamem.sv
texmem_top.sv
tb_texmem.sv

/* Bender.yml */
package:
  name: texmem

sources:
  - texmem_pkg.sv
  - texmem_tag_if.sv
  - texmem_buffer.sv
  - texmem_tagmem.sv
  - texmem_split.sv
  - texmem_fetchtexel.sv
  - texmem_datamem.sv
  - texmem_top.sv
  - target: simulation
    files:
      - tb_texmem.sv
